/* src/cpu_ctrl_consts.svh */
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

`define CPU_INSN_W 32
`define CPU_LANES 4

// instruction word fields
`define IR_MODE_LSB 29
`define IR_MODE_W 3
`define IR_OP_LSB 21
`define IR_OP_W 8
`define IR_RA_LSB 16
`define IR_RB_LSB 11
`define IR_RC_LSB 6
`define IR_REG_W 5

`define MODE_REG 3'h0
`define MODE_REGIND 3'h1
`define MODE_IMM 3'h2

`define ALU_FN_ADD 3'h2
`define ALU_FN_SUB 3'h3

// register mode
`define OP_NOP 8'h00
`define OP_CMP 8'h02
`define OP_INC 8'h03
`define OP_DEC 8'h04
`define OP_MOV 8'h07
`define OP_COM 8'h08
`define OP_NEG 8'h09
`define OP_ALU_GRP 4'h2

// immediate mode
`define OP_BRA 8'h00
`define OP_BEQ 8'h01
`define OP_BNE 8'h02
`define OP_BGTU 8'h03
`define OP_BGT 8'h04
`define OP_BGE 8'h05
`define OP_BLE 8'h06
`define OP_BLT 8'h07
`define OP_BGEU 8'h08
`define OP_BLTU 8'h09
`define OP_BLEU 8'h0a
`define OP_BRN 8'h0b
`define OP_LDIS 8'h0c
`define OP_LDIU 8'h0d

// register indirect mode
`define OP_STL 8'h00
`define OP_LDL 8'h01
`define OP_STW 8'h02
`define OP_LDW 8'h03
`define OP_STB 8'h04
`define OP_LDB 8'h05

`endif

/* src/cpu_ctrl_pkg.sv */
`default_nettype none
`include "cpu_ctrl_consts.svh"

package cpu_ctrl_pkg;

  typedef enum logic [1:0] {
    ST_FETCH   = 2'd0,
    ST_EXECUTE = 2'd1,
    ST_FAULT   = 2'd2,
    ST_RESET   = 2'd3
  } cycle_state_t;

  typedef enum logic [3:0] {
    CLS_NOP     = 4'd0,
    CLS_CMP     = 4'd1,
    CLS_INCDEC  = 4'd2,
    CLS_MOVE    = 4'd3,
    CLS_ALU     = 4'd4,
    CLS_BRANCH  = 4'd5,
    CLS_LOADIMM = 4'd6,
    CLS_LOAD    = 4'd7,
    CLS_STORE   = 4'd8,
    CLS_ILLEGAL = 4'd9
  } op_class_t;

  typedef logic [2:0] step_t;
  typedef logic [2:0] alu_func_t;

  typedef enum logic [2:0] {
    ALU2_RB  = 3'h0,
    ALU2_IND = 3'h1, // sign extended offset from ir
    ALU2_ONE = 3'h2
  } alu2_sel_t;

  typedef enum logic [2:0] {
    REG_ALU   = 3'h0,
    REG_MDR   = 3'h1,
    REG_NEG   = 3'h2,
    REG_COM   = 3'h3,
    REG_MOVE  = 3'h4,
    REG_IMM_S = 3'h5,
    REG_IMM_U = 3'h6
  } reg_sel_t;

  typedef enum logic [2:0] {
    MDR_HOLD  = 3'h0,
    MDR_BUS   = 3'h1,
    MDR_REG_A = 3'h3
  } mdr_sel_t;

  typedef enum logic [1:0] {
    MAR_HOLD = 2'h0,
    MAR_ALU  = 2'h2
  } mar_sel_t;

  typedef enum logic [2:0] {
    PC_HOLD   = 3'h0,
    PC_INC    = 3'h1,
    PC_REL    = 3'h3,
    PC_VECTOR = 3'h5
  } pc_sel_t;

  typedef enum logic [1:0] {
    REG_WR_NONE = 2'b00,
    REG_WR_DW   = 2'b11
  } reg_write_t;

  typedef enum logic [1:0] {
    SIZE_LONG = 2'd0,
    SIZE_WORD = 2'd1,
    SIZE_BYTE = 2'd2
  } mem_size_t;

  typedef logic [`IR_REG_W-1:0] reg_addr_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

endpackage

`default_nettype wire

/* src/insn_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_ctrl_consts.svh"

module insn_decoder (
  input  logic [`CPU_INSN_W-1:0]   ir,
  input  cpu_ctrl_pkg::ccr_t       ccr,
  output cpu_ctrl_pkg::op_class_t  op_class,
  output cpu_ctrl_pkg::alu_func_t  alu_func,
  output cpu_ctrl_pkg::mem_size_t  mem_size,
  output cpu_ctrl_pkg::reg_sel_t   write_src,
  output logic                     branch_taken,
  output cpu_ctrl_pkg::reg_addr_t  rd_addr_a,
  output cpu_ctrl_pkg::reg_addr_t  rd_addr_b,
  output cpu_ctrl_pkg::reg_addr_t  rd_addr_c
);
  import cpu_ctrl_pkg::*;

  logic [`IR_MODE_W-1:0] mode;
  logic [`IR_OP_W-1:0]   op;
  logic                  cond;

  assign mode = ir[`IR_MODE_LSB +: `IR_MODE_W];
  assign op   = ir[`IR_OP_LSB +: `IR_OP_W];

  assign rd_addr_a = ir[`IR_RA_LSB +: `IR_REG_W];
  assign rd_addr_b = ir[`IR_RB_LSB +: `IR_REG_W];
  assign rd_addr_c = ir[`IR_RC_LSB +: `IR_REG_W];

  always_comb begin
    op_class  = CLS_ILLEGAL;
    alu_func  = `ALU_FN_ADD;
    mem_size  = SIZE_LONG;
    write_src = REG_ALU;
    case (mode)
      `MODE_REG: begin
        if (op[7:4] == `OP_ALU_GRP && op[3] == 1'b0) begin
          op_class = CLS_ALU;
          alu_func = op[2:0]; // function straight from opcode
        end else begin
          case (op)
            `OP_NOP: op_class = CLS_NOP;
            `OP_CMP: begin
              op_class = CLS_CMP;
              alu_func = `ALU_FN_SUB;
            end
            `OP_INC: op_class = CLS_INCDEC;
            `OP_DEC: begin
              op_class = CLS_INCDEC;
              alu_func = `ALU_FN_SUB;
            end
            `OP_MOV: begin
              op_class  = CLS_MOVE;
              write_src = REG_MOVE;
            end
            `OP_COM: begin
              op_class  = CLS_MOVE;
              write_src = REG_COM;
            end
            `OP_NEG: begin
              op_class  = CLS_MOVE;
              write_src = REG_NEG;
            end
            default: op_class = CLS_ILLEGAL;
          endcase
        end
      end
      `MODE_IMM: begin
        if (op <= `OP_BRN) begin
          op_class = CLS_BRANCH;
        end else if (op == `OP_LDIS) begin
          op_class  = CLS_LOADIMM;
          write_src = REG_IMM_S;
        end else if (op == `OP_LDIU) begin
          op_class  = CLS_LOADIMM;
          write_src = REG_IMM_U;
        end
      end
      `MODE_REGIND: begin
        case (op)
          `OP_STL, `OP_STW, `OP_STB: op_class = CLS_STORE;
          `OP_LDL, `OP_LDW, `OP_LDB: op_class = CLS_LOAD;
          default: op_class = CLS_ILLEGAL;
        endcase
        case (op)
          `OP_STW, `OP_LDW: mem_size = SIZE_WORD;
          `OP_STB, `OP_LDB: mem_size = SIZE_BYTE;
          default: mem_size = SIZE_LONG;
        endcase
      end
      default: op_class = CLS_ILLEGAL;
    endcase
  end

  // branch condition on the flags
  always_comb begin
    case (op)
      `OP_BRA:  cond = 1'b1;
      `OP_BEQ:  cond = ccr.zero;
      `OP_BNE:  cond = ~ccr.zero;
      `OP_BGTU: cond = ~(ccr.zero | ccr.carry);
      `OP_BGT:  cond = ~(ccr.zero | (ccr.negative ^ ccr.overflow));
      `OP_BGE:  cond = ~(ccr.negative ^ ccr.overflow);
      `OP_BLE:  cond = ccr.zero | (ccr.negative ^ ccr.overflow);
      `OP_BLT:  cond = ccr.negative ^ ccr.overflow;
      `OP_BGEU: cond = ~ccr.carry;
      `OP_BLTU: cond = ccr.carry;
      `OP_BLEU: cond = ccr.carry | ccr.zero;
      `OP_BRN:  cond = 1'b0; // never
      default:  cond = 1'b0;
    endcase
  end

  assign branch_taken = (mode == `MODE_IMM) && cond;

endmodule

`default_nettype wire

/* src/cycle_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module cycle_sequencer (
  input  logic                       clock,
  input  logic                       reset_n,
  input  logic                       bus_wait,
  input  cpu_ctrl_pkg::op_class_t    op_class,
  output cpu_ctrl_pkg::cycle_state_t state,
  output cpu_ctrl_pkg::step_t        step,
  output logic                       fault
);
  import cpu_ctrl_pkg::*;

  cycle_state_t state_next;
  step_t        step_next;
  step_t        last_step;
  logic         mem_class;
  logic         bus_step;

  assign mem_class = (op_class == CLS_LOAD) || (op_class == CLS_STORE);

  // final execute step per class
  always_comb begin
    case (op_class)
      CLS_INCDEC, CLS_ALU: last_step = 3'd1;
      CLS_LOAD, CLS_STORE: last_step = 3'd3;
      default:             last_step = 3'd0;
    endcase
  end

  // steps that hold a bus strobe and stretch on bus_wait
  assign bus_step = (state == ST_FETCH && step == 3'd0) ||
                    (state == ST_EXECUTE && mem_class && step == 3'd2);

  always_comb begin
    state_next = state;
    step_next  = step;
    case (state)
      ST_RESET: begin
        state_next = ST_FETCH;
        step_next  = 3'd0;
      end
      ST_FETCH: begin
        if (step > 3'd2) begin
          state_next = ST_FAULT;
          step_next  = 3'd0;
        end else if (bus_step && bus_wait) begin
          step_next = step; // wait state
        end else if (step == 3'd2) begin
          state_next = ST_EXECUTE;
          step_next  = 3'd0;
        end else begin
          step_next = step + 3'd1;
        end
      end
      ST_EXECUTE: begin
        if (op_class == CLS_ILLEGAL || step > last_step) begin
          state_next = ST_FAULT;
          step_next  = 3'd0;
        end else if (bus_step && bus_wait) begin
          step_next = step;
        end else if (step == last_step) begin
          state_next = ST_FETCH;
          step_next  = 3'd0;
        end else begin
          step_next = step + 3'd1;
        end
      end
      default: begin
        state_next = ST_FAULT; // stuck until reset
        step_next  = 3'd0;
      end
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_RESET;
      step  <= 3'd0;
    end else begin
      state <= state_next;
      step  <= step_next;
    end
  end

  assign fault = (state == ST_FAULT);

endmodule

`default_nettype wire

/* src/control_word_gen.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_ctrl_consts.svh"

module control_word_gen (
  input  cpu_ctrl_pkg::cycle_state_t state,
  input  cpu_ctrl_pkg::step_t        step,
  input  cpu_ctrl_pkg::op_class_t    op_class,
  input  cpu_ctrl_pkg::alu_func_t    alu_func,
  input  cpu_ctrl_pkg::mem_size_t    mem_size,
  input  cpu_ctrl_pkg::reg_sel_t     write_src,
  input  logic                       branch_taken,
  input  cpu_ctrl_pkg::reg_addr_t    rd_addr_a,
  input  cpu_ctrl_pkg::reg_addr_t    rd_addr_b,
  input  cpu_ctrl_pkg::reg_addr_t    rd_addr_c,
  input  logic [1:0]                 bus_align,
  output logic                       ir_write,
  output logic                       ccr_write,
  output logic                       addrsel,
  output logic                       bus_read,
  output logic                       bus_write,
  output cpu_ctrl_pkg::alu_func_t    alu_func_out,
  output cpu_ctrl_pkg::alu2_sel_t    alu2sel,
  output cpu_ctrl_pkg::reg_sel_t     regsel,
  output cpu_ctrl_pkg::mdr_sel_t     mdrsel,
  output cpu_ctrl_pkg::mar_sel_t     marsel,
  output cpu_ctrl_pkg::pc_sel_t      pcsel,
  output cpu_ctrl_pkg::reg_write_t   reg_write,
  output cpu_ctrl_pkg::reg_addr_t    reg_read_addr1,
  output cpu_ctrl_pkg::reg_addr_t    reg_read_addr2,
  output cpu_ctrl_pkg::reg_addr_t    reg_write_addr,
  output logic [`CPU_LANES-1:0]      byteenable
);
  import cpu_ctrl_pkg::*;

  logic [`CPU_LANES-1:0] lane_mask;

  // lanes touched by the current access in big endian order
  always_comb begin
    case (mem_size)
      SIZE_WORD: lane_mask = bus_align[1] ? 4'b0011 : 4'b1100;
      SIZE_BYTE: begin
        case (bus_align)
          2'd0:    lane_mask = 4'b1000;
          2'd1:    lane_mask = 4'b0100;
          2'd2:    lane_mask = 4'b0010;
          default: lane_mask = 4'b0001;
        endcase
      end
      default:   lane_mask = {`CPU_LANES{1'b1}};
    endcase
  end

  always_comb begin
    ir_write       = 1'b0;
    ccr_write      = 1'b0;
    addrsel        = 1'b0; // PC drives the address
    bus_read       = 1'b0;
    bus_write      = 1'b0;
    alu_func_out   = `ALU_FN_ADD;
    alu2sel        = ALU2_RB;
    regsel         = REG_ALU;
    mdrsel         = MDR_HOLD;
    marsel         = MAR_HOLD;
    pcsel          = PC_HOLD;
    reg_write      = REG_WR_NONE;
    reg_read_addr1 = rd_addr_a;
    reg_read_addr2 = rd_addr_b;
    reg_write_addr = rd_addr_a;
    byteenable     = {`CPU_LANES{1'b1}};
    case (state)
      ST_RESET: pcsel = PC_VECTOR;
      ST_FETCH: begin
        case (step)
          3'd0: bus_read = 1'b1;
          3'd1: begin
            bus_read = 1'b1;
            ir_write = 1'b1; // capture the instruction
          end
          3'd2: pcsel = PC_INC;
          default: pcsel = PC_HOLD;
        endcase
      end
      ST_EXECUTE: begin
        alu_func_out = alu_func;
        case (op_class)
          CLS_CMP: ccr_write = 1'b1;
          CLS_INCDEC: begin
            if (step == 3'd0)
              alu2sel = ALU2_ONE;
            else
              reg_write = REG_WR_DW;
          end
          CLS_MOVE, CLS_LOADIMM: begin
            regsel    = write_src;
            reg_write = REG_WR_DW;
          end
          CLS_ALU: begin
            reg_read_addr1 = rd_addr_b;
            reg_read_addr2 = rd_addr_c;
            if (step == 3'd1)
              reg_write = REG_WR_DW;
          end
          CLS_BRANCH: begin
            if (branch_taken)
              pcsel = PC_REL;
          end
          CLS_LOAD, CLS_STORE: begin
            addrsel = 1'b1; // MAR drives the address
            case (step)
              3'd0: begin
                reg_read_addr1 = rd_addr_b;
                alu2sel        = ALU2_IND; // rB plus offset
              end
              3'd1: marsel = MAR_ALU;
              3'd2: begin
                byteenable = lane_mask;
                if (op_class == CLS_LOAD) begin
                  bus_read = 1'b1;
                  mdrsel   = MDR_BUS;
                end else begin
                  bus_write = 1'b1;
                  mdrsel    = MDR_REG_A;
                end
              end
              default: begin
                if (op_class == CLS_LOAD) begin
                  regsel    = REG_MDR;
                  reg_write = REG_WR_DW;
                end
              end
            endcase
          end
          default: ccr_write = 1'b0; // nop and illegal drive nothing
        endcase
      end
      default: pcsel = PC_HOLD;
    endcase
  end

endmodule

`default_nettype wire

/* src/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_ctrl_consts.svh"

module control_unit (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic                     bus_wait,
  input  logic [`CPU_INSN_W-1:0]   ir,
  input  cpu_ctrl_pkg::ccr_t       ccr,
  input  logic [1:0]               bus_align,
  output logic                     ir_write,
  output logic                     ccr_write,
  output logic                     addrsel,
  output logic                     bus_read,
  output logic                     bus_write,
  output cpu_ctrl_pkg::alu_func_t  alu_func,
  output cpu_ctrl_pkg::alu2_sel_t  alu2sel,
  output cpu_ctrl_pkg::reg_sel_t   regsel,
  output cpu_ctrl_pkg::mdr_sel_t   mdrsel,
  output cpu_ctrl_pkg::mar_sel_t   marsel,
  output cpu_ctrl_pkg::pc_sel_t    pcsel,
  output cpu_ctrl_pkg::reg_write_t reg_write,
  output cpu_ctrl_pkg::reg_addr_t  reg_read_addr1,
  output cpu_ctrl_pkg::reg_addr_t  reg_read_addr2,
  output cpu_ctrl_pkg::reg_addr_t  reg_write_addr,
  output logic [`CPU_LANES-1:0]    byteenable,
  output logic                     fault
);
  import cpu_ctrl_pkg::*;

  op_class_t    op_class;
  alu_func_t    dec_alu_func;
  mem_size_t    mem_size;
  reg_sel_t     write_src;
  logic         branch_taken;
  reg_addr_t    rd_addr_a;
  reg_addr_t    rd_addr_b;
  reg_addr_t    rd_addr_c;
  cycle_state_t state;
  step_t        step;

  insn_decoder decoder_i (
    .ir           (ir),
    .ccr          (ccr),
    .op_class     (op_class),
    .alu_func     (dec_alu_func),
    .mem_size     (mem_size),
    .write_src    (write_src),
    .branch_taken (branch_taken),
    .rd_addr_a    (rd_addr_a),
    .rd_addr_b    (rd_addr_b),
    .rd_addr_c    (rd_addr_c)
  );

  cycle_sequencer sequencer_i (
    .clock    (clock),
    .reset_n  (reset_n),
    .bus_wait (bus_wait),
    .op_class (op_class),
    .state    (state),
    .step     (step),
    .fault    (fault)
  );

  control_word_gen word_gen_i (
    .state          (state),
    .step           (step),
    .op_class       (op_class),
    .alu_func       (dec_alu_func),
    .mem_size       (mem_size),
    .write_src      (write_src),
    .branch_taken   (branch_taken),
    .rd_addr_a      (rd_addr_a),
    .rd_addr_b      (rd_addr_b),
    .rd_addr_c      (rd_addr_c),
    .bus_align      (bus_align),
    .ir_write       (ir_write),
    .ccr_write      (ccr_write),
    .addrsel        (addrsel),
    .bus_read       (bus_read),
    .bus_write      (bus_write),
    .alu_func_out   (alu_func),
    .alu2sel        (alu2sel),
    .regsel         (regsel),
    .mdrsel         (mdrsel),
    .marsel         (marsel),
    .pcsel          (pcsel),
    .reg_write      (reg_write),
    .reg_read_addr1 (reg_read_addr1),
    .reg_read_addr2 (reg_read_addr2),
    .reg_write_addr (reg_write_addr),
    .byteenable     (byteenable)
  );

endmodule

`default_nettype wire

/* testbench/control_unit_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit_assert (
  input logic                     clock,
  input logic                     reset_n,
  input logic                     bus_read,
  input logic                     bus_write,
  input logic                     ir_write,
  input logic                     ccr_write,
  input cpu_ctrl_pkg::reg_write_t reg_write,
  input logic                     fault
);
  import cpu_ctrl_pkg::*;

  logic strobes;

  assign strobes = bus_read | bus_write | ir_write | ccr_write | (reg_write != REG_WR_NONE);

  bus_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
    !(bus_read && bus_write))
    else $error("bus_read and bus_write high together");

  ir_needs_read: assert property (@(posedge clock) disable iff (!reset_n)
    ir_write |-> bus_read)
    else $error("ir_write without bus_read");

  fault_quiet: assert property (@(posedge clock) disable iff (!reset_n)
    fault |-> !strobes)
    else $error("strobe active in fault state");

  // fault only leaves through reset
  fault_sticky: assert property (@(posedge clock) disable iff (!reset_n)
    fault |=> fault)
    else $error("fault dropped without reset");

endmodule

bind control_unit control_unit_assert assert_i (
  .clock     (clock),
  .reset_n   (reset_n),
  .bus_read  (bus_read),
  .bus_write (bus_write),
  .ir_write  (ir_write),
  .ccr_write (ccr_write),
  .reg_write (reg_write),
  .fault     (fault)
);

`default_nettype wire

/* testbench/control_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_ctrl_consts.svh"

module control_unit_tb;
  import cpu_ctrl_pkg::*;

  logic                   clock;
  logic                   reset_n;
  logic                   bus_wait;
  logic [`CPU_INSN_W-1:0] ir;
  ccr_t                   ccr;
  logic [1:0]             bus_align;
  logic                   ir_write, ccr_write, addrsel, bus_read, bus_write;
  alu_func_t              alu_func;
  alu2_sel_t              alu2sel;
  reg_sel_t               regsel;
  mdr_sel_t               mdrsel;
  mar_sel_t               marsel;
  pc_sel_t                pcsel;
  reg_write_t             reg_write;
  reg_addr_t              reg_read_addr1, reg_read_addr2, reg_write_addr;
  logic [`CPU_LANES-1:0]  byteenable;
  logic                   fault;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;

  control_unit dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pc_sel(input string name, input pc_sel_t got, input pc_sel_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_alu2_sel(input string name, input alu2_sel_t got, input alu2_sel_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mdr_sel(input string name, input mdr_sel_t got, input mdr_sel_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mar_sel(input string name, input mar_sel_t got, input mar_sel_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg_write(input string name, input reg_write_t got,
                                 input reg_write_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_alu_func(input string name, input alu_func_t got, input alu_func_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byteenable(input string name, input logic [`CPU_LANES-1:0] got,
                                  input logic [`CPU_LANES-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [`CPU_INSN_W-1:0] make_insn(input logic [2:0] mode,
      input logic [7:0] op, input reg_addr_t ra, input reg_addr_t rb, input reg_addr_t rc);
    logic [`CPU_INSN_W-1:0] insn;
    insn = '0;
    insn[`IR_MODE_LSB +: `IR_MODE_W] = mode;
    insn[`IR_OP_LSB +: `IR_OP_W]     = op;
    insn[`IR_RA_LSB +: `IR_REG_W]    = ra;
    insn[`IR_RB_LSB +: `IR_REG_W]    = rb;
    insn[`IR_RC_LSB +: `IR_REG_W]    = rc;
    return insn;
  endfunction

  function automatic int rand_waits();
    return $unsigned($random(seed)) % 4;
  endfunction

  // flags are {carry, negative, overflow, zero}
  function automatic logic branch_expected(input int op, input logic [3:0] flags);
    logic c;
    logic n;
    logic v;
    logic z;
    c = flags[3];
    n = flags[2];
    v = flags[1];
    z = flags[0];
    case (op)
      0:  return 1'b1;
      1:  return z;
      2:  return !z;
      3:  return !c && !z; // unsigned greater
      4:  return !z && (n == v);
      5:  return n == v;
      6:  return z || (n != v);
      7:  return n != v;
      8:  return !c;
      9:  return c;
      10: return c || z;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [`CPU_LANES-1:0] expected_lanes(input int size, input logic [1:0] align);
    case (size)
      0: return 4'b1111;
      1: return align[1] ? 4'b0011 : 4'b1100;
      default: return 4'b1000 >> align; // lane 0 is the high byte
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    @(negedge clock);
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", name, errors - start);
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset_n <= 1'b0;
    repeat (5) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    check_pc_sel("pcsel", pcsel, PC_VECTOR); // the single RESET cycle
    check_bit("fault", fault, 1'b0);
    check_bit("bus_read", bus_read, 1'b0);
    check_reg_write("reg_write", reg_write, REG_WR_NONE);
  endtask

  // expects FETCH step 0 to start on the next rising edge and returns in step 2
  task automatic fetch_insn(input logic [`CPU_INSN_W-1:0] insn, input logic [3:0] flags,
                            input logic [1:0] align, input int waits);
    int n;
    int reads;
    n = 0;
    reads = 0;
    @(posedge clock);
    ir        <= insn;
    ccr       <= flags;
    bus_align <= align;
    bus_wait  <= (waits > 0);
    @(negedge clock);
    check_pc_sel("pcsel", pcsel, PC_HOLD);
    check_reg_write("reg_write", reg_write, REG_WR_NONE);
    check_bit("addrsel", addrsel, 1'b0);
    while (!ir_write && n < 50) begin
      if (bus_read)
        reads++;
      n++;
      @(posedge clock);
      bus_wait <= (n < waits);
      @(negedge clock);
    end
    if (n >= 50) begin
      $display("timeout: the fetch never raised ir_write");
      errors++;
    end
    check_count("fetch bus_read cycles", reads, waits + 1);
    check_bit("bus_read", bus_read, 1'b1);
    next_cycle();
    check_bit("ir_write", ir_write, 1'b0);
    check_bit("bus_read", bus_read, 1'b0);
    check_pc_sel("pcsel", pcsel, PC_INC);
  endtask

  task automatic test_reset_fetch();
    int start;
    int k;
    start = errors;
    apply_reset();
    for (k = 0; k < 3; k++) begin
      fetch_insn(make_insn(`MODE_REG, `OP_NOP, 5'd0, 5'd0, 5'd0), 4'h0, 2'd0, rand_waits());
      next_cycle();
      check_bit("ccr_write", ccr_write, 1'b0);
      check_reg_write("reg_write", reg_write, REG_WR_NONE);
    end
    finish_test("reset and fetch", start);
  endtask

  task automatic test_reg_ops();
    int         start;
    int         k;
    logic [7:0] op;
    reg_sel_t   exp_sel;
    start = errors;
    fetch_insn(make_insn(`MODE_REG, `OP_CMP, 5'd1, 5'd2, 5'd3), 4'h0, 2'd0, rand_waits());
    next_cycle();
    check_bit("ccr_write", ccr_write, 1'b1);
    check_alu_func("alu_func", alu_func, `ALU_FN_SUB);
    check_reg_write("reg_write", reg_write, REG_WR_NONE);
    for (k = 0; k < 2; k++) begin
      op = (k == 0) ? `OP_INC : `OP_DEC;
      fetch_insn(make_insn(`MODE_REG, op, 5'd7, 5'd7, 5'd0), 4'h0, 2'd0, rand_waits());
      next_cycle();
      check_reg_write("reg_write", reg_write, REG_WR_NONE);
      check_alu_func("alu_func", alu_func, (k == 0) ? `ALU_FN_ADD : `ALU_FN_SUB);
      check_alu2_sel("alu2sel", alu2sel, ALU2_ONE);
      next_cycle();
      check_reg_write("reg_write", reg_write, REG_WR_DW);
      check_reg_sel("regsel", regsel, REG_ALU);
    end
    for (k = 0; k < 3; k++) begin
      case (k)
        0: begin
          op = `OP_MOV;
          exp_sel = REG_MOVE;
        end
        1: begin
          op = `OP_COM;
          exp_sel = REG_COM;
        end
        default: begin
          op = `OP_NEG;
          exp_sel = REG_NEG;
        end
      endcase
      fetch_insn(make_insn(`MODE_REG, op, 5'd9, 5'd10, 5'd0), 4'h0, 2'd0, rand_waits());
      next_cycle();
      check_reg_sel("regsel", regsel, exp_sel);
      check_reg_write("reg_write", reg_write, REG_WR_DW);
      check_reg_addr("reg_write_addr", reg_write_addr, 5'd9);
    end
    for (k = 0; k < 8; k++) begin
      op = {4'h2, 1'b0, 3'(k)}; // ALU group 0x20 to 0x27
      fetch_insn(make_insn(`MODE_REG, op, 5'(k), 5'(k + 8), 5'(k + 16)), 4'h0, 2'd0,
                 rand_waits());
      next_cycle();
      check_reg_addr("reg_read_addr1", reg_read_addr1, 5'(k + 8));
      check_reg_addr("reg_read_addr2", reg_read_addr2, 5'(k + 16));
      check_alu_func("alu_func", alu_func, 3'(k));
      check_alu2_sel("alu2sel", alu2sel, ALU2_RB);
      check_reg_write("reg_write", reg_write, REG_WR_NONE);
      next_cycle();
      check_reg_write("reg_write", reg_write, REG_WR_DW);
      check_reg_addr("reg_write_addr", reg_write_addr, 5'(k));
    end
    finish_test("register operations", start);
  endtask

  task automatic test_branches();
    int         start;
    int         op;
    int         r;
    logic [3:0] flags;
    start = errors;
    for (op = 0; op <= 11; op++) begin
      for (r = 0; r < 3; r++) begin
        flags = 4'($random(seed));
        fetch_insn(make_insn(`MODE_IMM, 8'(op), 5'd0, 5'd0, 5'd0), flags, 2'd0, 0);
        next_cycle();
        check_pc_sel("pcsel", pcsel, branch_expected(op, flags) ? PC_REL : PC_HOLD);
        check_reg_write("reg_write", reg_write, REG_WR_NONE);
      end
    end
    finish_test("branches", start);
  endtask

  task automatic test_load_store();
    int         start;
    int         k;
    int         r;
    int         n;
    int         strobes;
    int         mem_waits;
    logic       is_load;
    logic [1:0] align;
    start = errors;
    for (k = 0; k < 6; k++) begin
      for (r = 0; r < 2; r++) begin
        is_load   = k[0];
        align     = 2'($random(seed));
        mem_waits = rand_waits();
        fetch_insn(make_insn(`MODE_REGIND, 8'(k), 5'd4, 5'd5, 5'd0), 4'h0, align, rand_waits());
        next_cycle(); // address add
        check_bit("addrsel", addrsel, 1'b1);
        check_reg_addr("reg_read_addr1", reg_read_addr1, 5'd5);
        check_alu2_sel("alu2sel", alu2sel, ALU2_IND);
        check_mar_sel("marsel", marsel, MAR_HOLD);
        check_bit("bus_read", bus_read, 1'b0);
        check_bit("bus_write", bus_write, 1'b0);
        next_cycle(); // MAR load
        check_bit("addrsel", addrsel, 1'b1);
        check_mar_sel("marsel", marsel, MAR_ALU);
        @(posedge clock);
        bus_wait <= (mem_waits > 0);
        @(negedge clock);
        n = 0;
        strobes = 0;
        while ((bus_read || bus_write) && n < 50) begin
          check_byteenable("byteenable", byteenable, expected_lanes(k / 2, align));
          check_bit("bus_read", bus_read, is_load);
          check_bit("bus_write", bus_write, !is_load);
          check_bit("addrsel", addrsel, 1'b1);
          check_mdr_sel("mdrsel", mdrsel, is_load ? MDR_BUS : MDR_REG_A);
          check_mar_sel("marsel", marsel, MAR_HOLD);
          strobes++;
          n++;
          @(posedge clock);
          bus_wait <= (n < mem_waits);
          @(negedge clock);
        end
        if (n >= 50) begin
          $display("timeout: the memory strobe never dropped");
          errors++;
        end
        check_count("memory strobe cycles", strobes, mem_waits + 1);
        check_byteenable("byteenable", byteenable, 4'b1111);
        check_mdr_sel("mdrsel", mdrsel, MDR_HOLD);
        if (is_load) begin
          check_reg_sel("regsel", regsel, REG_MDR);
          check_reg_write("reg_write", reg_write, REG_WR_DW);
          check_reg_addr("reg_write_addr", reg_write_addr, 5'd4);
        end else begin
          check_reg_write("reg_write", reg_write, REG_WR_NONE);
        end
      end
    end
    finish_test("loads and stores", start);
  endtask

  task automatic test_load_imm();
    int start;
    start = errors;
    fetch_insn(make_insn(`MODE_IMM, `OP_LDIS, 5'd12, 5'd0, 5'd0), 4'h0, 2'd0, rand_waits());
    next_cycle();
    check_reg_sel("regsel", regsel, REG_IMM_S);
    check_reg_write("reg_write", reg_write, REG_WR_DW);
    check_reg_addr("reg_write_addr", reg_write_addr, 5'd12);
    fetch_insn(make_insn(`MODE_IMM, `OP_LDIU, 5'd13, 5'd0, 5'd0), 4'h0, 2'd0, rand_waits());
    next_cycle();
    check_reg_sel("regsel", regsel, REG_IMM_U);
    check_reg_write("reg_write", reg_write, REG_WR_DW);
    check_reg_addr("reg_write_addr", reg_write_addr, 5'd13);
    finish_test("load immediate", start); // next fetch checks the write was one cycle
  endtask

  task automatic test_fault();
    int start;
    int k;
    start = errors;
    fetch_insn(make_insn(`MODE_REG, 8'h01, 5'd0, 5'd0, 5'd0), 4'h0, 2'd0, rand_waits());
    next_cycle();
    check_bit("fault", fault, 1'b0);
    for (k = 0; k < 20; k++) begin
      next_cycle();
      check_bit("fault", fault, 1'b1);
      check_bit("bus_read", bus_read, 1'b0);
      check_bit("bus_write", bus_write, 1'b0);
      check_bit("ir_write", ir_write, 1'b0);
      check_bit("ccr_write", ccr_write, 1'b0);
      check_reg_write("reg_write", reg_write, REG_WR_NONE);
    end
    apply_reset();
    fetch_insn(make_insn(`MODE_REG, `OP_NOP, 5'd0, 5'd0, 5'd0), 4'h0, 2'd0, rand_waits());
    next_cycle();
    check_bit("fault", fault, 1'b0);
    finish_test("fault and recovery", start);
  endtask

  initial begin
    seed         = 85;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_n      = 1'b0;
    bus_wait     = 1'b0;
    ir           = '0;
    ccr          = '0;
    bus_align    = 2'd0;
    test_reset_fetch();
    test_reg_ops();
    test_branches();
    test_load_store();
    test_load_imm();
    test_fault();
    $display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/cpu_ctrl_pkg.sv
src/insn_decoder.sv
src/cycle_sequencer.sv
src/control_word_gen.sv
src/control_unit.sv
testbench/control_unit_assert.sv
testbench/control_unit_tb.sv

/* Makefile */
TOP = control_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
